//--- design/dma_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_backend import dma_xfer_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // queue head
    input  xfer_t                      head_i,
    input  logic                       valid_i,
    output logic                       pop_o,
    // completion to the id generator
    output logic                       retire_o,
    output logic                       busy_o,
    // beat stream
    output logic                       beat_o,
    output logic [`DMA_ADDR_WIDTH-1:0] beat_src_o,
    output logic [`DMA_ADDR_WIDTH-1:0] beat_dst_o
);

    be_state_e                  state_q;
    be_state_e                  state_d;
    // beats still to emit
    logic [`DMA_LEN_WIDTH-1:0]  rem_q;
    logic [`DMA_ADDR_WIDTH-1:0] src_q;
    logic [`DMA_ADDR_WIDTH-1:0] dst_q;

    // ------------------------------
    // FSM
    // ------------------------------
    // take a job whenever idle and one waits
    assign pop_o    = (state_q == BE_IDLE) && valid_i;
    assign busy_o   = (state_q == BE_MOVE);
    assign beat_o   = busy_o && (rem_q != '0);
    // last beat, or zero length on first move cycle
    assign retire_o = busy_o && (rem_q <= `DMA_LEN_WIDTH'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            BE_IDLE: if (pop_o) state_d = BE_MOVE;
            BE_MOVE: if (retire_o) state_d = BE_IDLE;
            default: state_d = BE_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= BE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture on pop, then step per beat
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            src_q <= head_i.src;
            dst_q <= head_i.dst;
            rem_q <= head_i.len;
        end else if (beat_o) begin
            src_q <= src_q + 1'b1;
            dst_q <= dst_q + 1'b1;
            rem_q <= rem_q - 1'b1;
        end
    end

    assign beat_src_o = src_q;
    assign beat_dst_o = dst_q;

    // retire ends the move, back to idle next cycle
    a_retire_move: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retire_o |-> (state_q == BE_MOVE) ##1 (state_q == BE_IDLE));

endmodule : dma_backend

`default_nettype wire

//--- design/dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// id counter width, kept small so the wrap shows up quickly
`define DMA_ID_WIDTH 4

// word address width for src and dst
`define DMA_ADDR_WIDTH 16

// transfer length in beats
`define DMA_LEN_WIDTH 8

// software register data width
`define DMA_DATA_WIDTH 16

// launched jobs waiting for the backend
`define DMA_QUEUE_DEPTH 4

`endif

//--- design/dma_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_frontend_top import dma_reg_pkg::*, dma_xfer_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       reg_wr_i,
    input  logic                       reg_rd_i,
    input  logic [2:0]                 reg_addr_i,
    input  logic [`DMA_DATA_WIDTH-1:0] reg_wdata_i,
    output logic [`DMA_DATA_WIDTH-1:0] reg_rdata_o,
    output logic                       reg_rvalid_o,
    output logic                       beat_o,
    output logic [`DMA_ADDR_WIDTH-1:0] beat_src_o,
    output logic [`DMA_ADDR_WIDTH-1:0] beat_dst_o
);

    // ------------------------------
    // internal wiring
    // ------------------------------
    dma_job_if job_if ();

    xfer_t                    head;
    logic                     head_valid;
    logic                     pop;
    logic                     issue;
    logic                     retire;
    logic                     busy;
    logic [`DMA_ID_WIDTH-1:0] next_id;
    logic [`DMA_ID_WIDTH-1:0] done_id;

    dma_reg_file u_reg_file (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .reg_wr_i     (reg_wr_i),
        .reg_rd_i     (reg_rd_i),
        .reg_addr_i   (reg_addr_e'(reg_addr_i)),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rvalid_o (reg_rvalid_o),
        .next_id_i    (next_id),
        .done_id_i    (done_id),
        .busy_i       (busy),
        .issue_o      (issue),
        .job_o        (job_if.issuer)
    );

    dma_job_queue #(
        .Depth (`DMA_QUEUE_DEPTH)
    ) u_job_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .job_i   (job_if.queue),
        .pop_i   (pop),
        .head_o  (head),
        .valid_o (head_valid)
    );

    dma_backend u_backend (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .head_i     (head),
        .valid_i    (head_valid),
        .pop_o      (pop),
        .retire_o   (retire),
        .busy_o     (busy),
        .beat_o     (beat_o),
        .beat_src_o (beat_src_o),
        .beat_dst_o (beat_dst_o)
    );

    // id bookkeeping
    transfer_id_gen #(
        .IdWidth (`DMA_ID_WIDTH)
    ) u_id_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .issue_i     (issue),
        .retire_i    (retire),
        .next_o      (next_id),
        .completed_o (done_id)
    );

endmodule : dma_frontend_top

`default_nettype wire

//--- design/dma_job_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

// launched job from the register file into the queue
interface dma_job_if;

    // one-cycle launch strobe
    logic                       push;
    // job fields, valid with push
    logic [`DMA_ADDR_WIDTH-1:0] src;
    logic [`DMA_ADDR_WIDTH-1:0] dst;
    logic [`DMA_LEN_WIDTH-1:0]  len;
    logic [`DMA_ID_WIDTH-1:0]   id;
    // queue has no free entry
    logic                       full;

    // register file side, only pushes while full is low
    modport issuer (
        output push, src, dst, len, id,
        input  full
    );

    modport queue (
        input  push, src, dst, len, id,
        output full
    );

endinterface : dma_job_if

`default_nettype wire

//--- design/dma_job_queue.sv
`timescale 1ns/1ps
`default_nettype none

module dma_job_queue import dma_xfer_pkg::*; #(
    parameter int unsigned Depth = 4
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    // launched jobs come in here
    dma_job_if.queue job_i,
    // backend takes the head
    input  logic    pop_i,
    output xfer_t   head_o,
    output logic    valid_o
);

    localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW = $clog2(Depth + 1);

    xfer_t            mem_q [Depth];
    logic [PtrW-1:0]  wr_ptr_q;
    logic [PtrW-1:0]  rd_ptr_q;
    logic [CntW-1:0]  count_q;

    // ------------------------------
    // pointers and fill level
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (job_i.push) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the level alone
            case ({job_i.push, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // storage, no reset needed
    always_ff @(posedge clk_i) begin
        if (job_i.push) begin
            mem_q[wr_ptr_q] <= '{
                src: job_i.src,
                dst: job_i.dst,
                len: job_i.len,
                id:  job_i.id
            };
        end
    end

    assign job_i.full = (count_q == CntW'(Depth));
    assign valid_o    = (count_q != '0);
    // oldest entry
    assign head_o     = mem_q[rd_ptr_q];

    // backend must only take a job that is there
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> valid_o);

    // a push into an empty queue shows up as the head next cycle
    a_push_visible: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (job_i.push && !valid_o) |=> (valid_o && (head_o.id == $past(job_i.id))));

endmodule : dma_job_queue

`default_nettype wire

//--- design/dma_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module dma_reg_file import dma_reg_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // software access
    input  logic                       reg_wr_i,
    input  logic                       reg_rd_i,
    input  reg_addr_e                  reg_addr_i,
    input  logic [`DMA_DATA_WIDTH-1:0] reg_wdata_i,
    output logic [`DMA_DATA_WIDTH-1:0] reg_rdata_o,
    output logic                       reg_rvalid_o,
    // id generator and backend state
    input  logic [`DMA_ID_WIDTH-1:0]   next_id_i,
    input  logic [`DMA_ID_WIDTH-1:0]   done_id_i,
    input  logic                       busy_i,
    // launch strobe to the id generator
    output logic                       issue_o,
    dma_job_if.issuer                  job_o
);

    localparam int unsigned DataW = `DMA_DATA_WIDTH;

    logic [`DMA_ADDR_WIDTH-1:0] src_q;
    logic [`DMA_ADDR_WIDTH-1:0] dst_q;
    logic [`DMA_LEN_WIDTH-1:0]  len_q;
    logic [DataW-1:0]           rdata_d;
    logic [DataW-1:0]           rdata_q;
    logic                       rvalid_q;

    // ------------------------------
    // config registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            src_q <= '0;
            dst_q <= '0;
            len_q <= '0;
        end else if (reg_wr_i) begin
            case (reg_addr_i)
                REG_SRC: src_q <= reg_wdata_i[`DMA_ADDR_WIDTH-1:0];
                REG_DST: dst_q <= reg_wdata_i[`DMA_ADDR_WIDTH-1:0];
                REG_LEN: len_q <= reg_wdata_i[`DMA_LEN_WIDTH-1:0];
                // id and status regs ignore writes
                default: ;
            endcase
        end
    end

    // launch only when the queue has room
    assign issue_o = reg_rd_i && (reg_addr_i == REG_NEXT_ID) && !job_o.full;

    // job fields follow the current config
    assign job_o.push = issue_o;
    assign job_o.src  = src_q;
    assign job_o.dst  = dst_q;
    assign job_o.len  = len_q;
    assign job_o.id   = next_id_i;

    // ------------------------------
    // read path
    // ------------------------------
    always_comb begin
        rdata_d = '0;
        case (reg_addr_i)
            REG_SRC:     rdata_d = DataW'(src_q);
            REG_DST:     rdata_d = DataW'(dst_q);
            REG_LEN:     rdata_d = DataW'(len_q);
            // 0 means the queue was full, no launch
            REG_NEXT_ID: rdata_d = job_o.full ? '0 : DataW'(next_id_i);
            REG_DONE_ID: rdata_d = DataW'(done_id_i);
            // bit 0 full, bit 1 busy
            REG_STATUS:  rdata_d = DataW'({busy_i, job_o.full});
            default:     rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= reg_rd_i;
        end
    end

    // data only matters while rvalid is high
    always_ff @(posedge clk_i) begin
        if (reg_rd_i) begin
            rdata_q <= rdata_d;
        end
    end

    assign reg_rdata_o  = rdata_q;
    assign reg_rvalid_o = rvalid_q;

    // a launch answers with the nonzero id one cycle later
    a_push_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        job_o.push |-> !job_o.full ##1 (reg_rvalid_o && (reg_rdata_o != '0)));

endmodule : dma_reg_file

`default_nettype wire

//--- design/dma_reg_pkg.sv
`default_nettype none

package dma_reg_pkg;

    // ------------------------------
    // software register map
    // ------------------------------
    // src, dst, len are read/write
    // next_id read launches a transfer
    // done_id and status are read-only
    typedef enum logic [2:0] {
        REG_SRC     = 3'd0,
        REG_DST     = 3'd1,
        REG_LEN     = 3'd2,
        REG_NEXT_ID = 3'd3,
        REG_DONE_ID = 3'd4,
        REG_STATUS  = 3'd5
    } reg_addr_e;

endpackage : dma_reg_pkg

`default_nettype wire

//--- design/dma_xfer_pkg.sv
`default_nettype none

`include "dma_consts.svh"

package dma_xfer_pkg;

    // ------------------------------
    // one launched transfer
    // ------------------------------
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] src;
        logic [`DMA_ADDR_WIDTH-1:0] dst;
        logic [`DMA_LEN_WIDTH-1:0]  len;
        logic [`DMA_ID_WIDTH-1:0]   id;
    } xfer_t;

    // backend sequencing
    typedef enum logic {
        BE_IDLE = 1'b0,
        BE_MOVE = 1'b1
    } be_state_e;

endpackage : dma_xfer_pkg

`default_nettype wire

//--- design/transfer_id_gen.sv
`timescale 1ns/1ps
`default_nettype none

// issued and completed id counters, zero is never produced
module transfer_id_gen #(
    parameter int unsigned IdWidth = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // a transfer was launched
    input  logic               issue_i,
    // a transfer finished its last beat
    input  logic               retire_i,
    // id handed to the next launch
    output logic [IdWidth-1:0] next_o,
    // id of the most recent completion
    output logic [IdWidth-1:0] completed_o
);

    logic [IdWidth-1:0] next_q;
    logic [IdWidth-1:0] completed_q;

    // advance on event, all-ones goes back to 1
    // without an event the value just holds, even at all-ones
    function automatic logic [IdWidth-1:0] step_id(
        input logic [IdWidth-1:0] cur,
        input logic               ev
    );
        logic [IdWidth-1:0] nxt;
        nxt = cur;
        if (ev) begin
            nxt = (cur == '1) ? IdWidth'(1) : cur + 1'b1;
        end
        return nxt;
    endfunction

    // ------------------------------
    // counter state
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            next_q      <= IdWidth'(2);
            completed_q <= IdWidth'(1);
        end else begin
            next_q      <= step_id(next_q, issue_i);
            completed_q <= step_id(completed_q, retire_i);
        end
    end

    assign next_o      = next_q;
    assign completed_o = completed_q;

    // zero must stay free as the "nothing issued" answer
    a_next_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_i |=> (next_o != '0) && (next_o != $past(next_o)));

endmodule : transfer_id_gen

`default_nettype wire

//--- flist.f
+incdir+design
design/dma_reg_pkg.sv
design/dma_xfer_pkg.sv
design/dma_job_if.sv
design/transfer_id_gen.sv
design/dma_reg_file.sv
design/dma_job_queue.sv
design/dma_backend.sv
design/dma_frontend_top.sv
test/tb_dma_frontend.sv

//--- run.sh
#!/usr/bin/env bash
# build the DMA frontend testbench with Verilator, run it, then check the log

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_dma_frontend \
    -Mdir "$build_dir" -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^all tests passed$" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

//--- test/tb_dma_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_consts.svh"

module tb_dma_frontend import dma_reg_pkg::*, dma_xfer_pkg::*; ();

    localparam int IdW        = `DMA_ID_WIDTH;
    localparam int AddrW      = `DMA_ADDR_WIDTH;
    localparam int LenW       = `DMA_LEN_WIDTH;
    localparam int DataW      = `DMA_DATA_WIDTH;
    localparam int ClkPeriod  = 100;
    localparam int NumXfers   = 20;
    localparam int MaxLen     = 6;
    localparam int LongLen    = 40;
    // every transfer gets its beats plus register traffic and slack
    localparam int WatchdogCycles = (NumXfers + 12) * (MaxLen + 24) + 2 * LongLen + 500;

    logic             clk;
    logic             rst_n;
    logic             reg_wr;
    logic             reg_rd;
    logic [2:0]       reg_addr;
    logic [DataW-1:0] reg_wdata;
    logic [DataW-1:0] reg_rdata;
    logic             reg_rvalid;
    logic             beat;
    logic [AddrW-1:0] beat_src;
    logic [AddrW-1:0] beat_dst;

    int errors;
    int n_reads;
    int n_beats;
    int full_hits;
    int next_wrap_hits;
    int done_wrap_hits;
    int zero_len_hits;

    dma_frontend_top dma_frontend_top_inst (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .reg_wr_i     (reg_wr),
        .reg_rd_i     (reg_rd),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_rdata_o  (reg_rdata),
        .reg_rvalid_o (reg_rvalid),
        .beat_o       (beat),
        .beat_src_o   (beat_src),
        .beat_dst_o   (beat_dst)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // ------------------------------
    // reference model
    // ------------------------------
    xfer_t            model_q [$];
    xfer_t            cur_job;
    logic             m_busy;
    // beats already sent for cur_job
    logic [LenW-1:0]  m_k;
    logic [AddrW-1:0] m_src;
    logic [AddrW-1:0] m_dst;
    logic [LenW-1:0]  m_len;
    logic [IdW-1:0]   m_next;
    logic [IdW-1:0]   m_done;
    logic             m_rvalid;
    logic [DataW-1:0] m_rdata;
    logic             exp_beat;
    logic [AddrW-1:0] exp_bsrc;
    logic [AddrW-1:0] exp_bdst;

    assign exp_beat = m_busy && (m_k < cur_job.len);
    assign exp_bsrc = cur_job.src + AddrW'(m_k);
    assign exp_bdst = cur_job.dst + AddrW'(m_k);

    // ids never take the value zero
    function automatic logic [IdW-1:0] following_id(input logic [IdW-1:0] id);
        logic [IdW-1:0] nxt;
        nxt = (&id) ? IdW'(1) : id + IdW'(1);
        return nxt;
    endfunction

    function automatic logic [DataW-1:0] expected_read(input logic [2:0] addr,
                                                       input logic full);
        logic [DataW-1:0] value;
        value = '0;
        case (addr)
            REG_SRC:     value = DataW'(m_src);
            REG_DST:     value = DataW'(m_dst);
            REG_LEN:     value = DataW'(m_len);
            // full queue answers zero
            REG_NEXT_ID: value = full ? '0 : DataW'(m_next);
            REG_DONE_ID: value = DataW'(m_done);
            REG_STATUS:  value = DataW'({m_busy, full});
            default:     value = '0;
        endcase
        return value;
    endfunction

    // steps once per edge from the inputs only, old state first
    always @(posedge clk or negedge rst_n) begin : model_step
        logic  full_now;
        logic  launch;
        xfer_t new_job;
        if (!rst_n) begin
            model_q.delete();
            cur_job  = '0;
            m_busy   = 1'b0;
            m_k      = '0;
            m_src    = '0;
            m_dst    = '0;
            m_len    = '0;
            m_next   = IdW'(2);
            m_done   = IdW'(1);
            m_rvalid = 1'b0;
            m_rdata  = '0;
        end else begin
            full_now = (model_q.size() == `DMA_QUEUE_DEPTH);
            launch   = reg_rd && (reg_addr == REG_NEXT_ID) && !full_now;
            new_job  = '{src: m_src, dst: m_dst, len: m_len, id: m_next};
            m_rvalid = reg_rd;
            if (reg_rd) begin
                m_rdata = expected_read(reg_addr, full_now);
                n_reads++;
                if ((reg_addr == REG_NEXT_ID) && full_now) full_hits++;
            end
            if (reg_wr) begin
                case (reg_addr)
                    REG_SRC: m_src = reg_wdata[AddrW-1:0];
                    REG_DST: m_dst = reg_wdata[AddrW-1:0];
                    REG_LEN: m_len = reg_wdata[LenW-1:0];
                    default: ;
                endcase
            end
            // backend: retire on last beat, idle one cycle, then pop
            if (m_busy) begin
                if (m_k < cur_job.len) n_beats++;
                if (int'(m_k) + 1 >= int'(cur_job.len)) begin
                    m_busy = 1'b0;
                    if (cur_job.len == '0) zero_len_hits++;
                    if (&m_done) done_wrap_hits++;
                    m_done = following_id(m_done);
                end else begin
                    m_k = m_k + LenW'(1);
                end
            end else if (model_q.size() != 0) begin
                cur_job = model_q.pop_front();
                m_k     = '0;
                m_busy  = 1'b1;
            end
            if (launch) begin
                model_q.push_back(new_job);
                if (&m_next) next_wrap_hits++;
                m_next = following_id(m_next);
            end
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("error %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic report_issue(input string what);
        errors++;
        $display("check failed: %s", what);
    endtask

    a_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        reg_rvalid == m_rvalid)
        else report_value("reg_rvalid_o", 32'($sampled(reg_rvalid)), 32'($sampled(m_rvalid)));

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        m_rvalid |-> (reg_rdata == m_rdata))
        else report_value("reg_rdata_o", 32'($sampled(reg_rdata)), 32'($sampled(m_rdata)));

    a_beat: assert property (@(posedge clk) disable iff (!rst_n)
        beat == exp_beat)
        else report_value("beat_o", 32'($sampled(beat)), 32'($sampled(exp_beat)));

    a_beat_src: assert property (@(posedge clk) disable iff (!rst_n)
        exp_beat |-> (beat_src == exp_bsrc))
        else report_value("beat_src_o", 32'($sampled(beat_src)), 32'($sampled(exp_bsrc)));

    a_beat_dst: assert property (@(posedge clk) disable iff (!rst_n)
        exp_beat |-> (beat_dst == exp_bdst))
        else report_value("beat_dst_o", 32'($sampled(beat_dst)), 32'($sampled(exp_bdst)));

    // ------------------------------
    // register access
    // ------------------------------
    task automatic write_reg(input logic [2:0] addr, input logic [DataW-1:0] data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [DataW-1:0] data);
        @(negedge clk);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        // response holds for this whole cycle
        data = reg_rdata;
    endtask

    task automatic launch_job(input logic [AddrW-1:0] src, input logic [AddrW-1:0] dst,
                              input logic [LenW-1:0] len, output logic [IdW-1:0] id);
        logic [DataW-1:0] data;
        write_reg(REG_SRC, DataW'(src));
        write_reg(REG_DST, DataW'(dst));
        write_reg(REG_LEN, DataW'(len));
        read_reg(REG_NEXT_ID, data);
        id = data[IdW-1:0];
    endtask

    // poll status until bit 0 drops
    task automatic wait_queue_room();
        logic [DataW-1:0] data;
        read_reg(REG_STATUS, data);
        while (data[0]) read_reg(REG_STATUS, data);
    endtask

    task automatic wait_for_done(input logic [IdW-1:0] id);
        logic [DataW-1:0] data;
        read_reg(REG_DONE_ID, data);
        while (data != DataW'(id)) read_reg(REG_DONE_ID, data);
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin : stimulus
        logic [DataW-1:0] data;
        logic [IdW-1:0]   id;
        logic [IdW-1:0]   last_id;
        void'($urandom(32'h2ff6_c919));
        errors         = 0;
        n_reads        = 0;
        n_beats        = 0;
        full_hits      = 0;
        next_wrap_hits = 0;
        done_wrap_hits = 0;
        zero_len_hits  = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset values, then readback
        read_reg(REG_STATUS, data);
        read_reg(REG_SRC, data);
        read_reg(REG_LEN, data);
        read_reg(REG_DONE_ID, data);
        write_reg(REG_SRC, DataW'($urandom));
        write_reg(REG_DST, DataW'($urandom));
        write_reg(REG_LEN, DataW'($urandom));
        read_reg(REG_SRC, data);
        read_reg(REG_DST, data);
        read_reg(REG_LEN, data);

        // a few ids in a row, one with no beats
        launch_job(AddrW'($urandom), AddrW'($urandom), LenW'(0), last_id);
        launch_job(AddrW'($urandom), AddrW'($urandom), LenW'(3), last_id);
        launch_job(AddrW'($urandom), AddrW'($urandom), LenW'(1), last_id);
        wait_for_done(last_id);

        // long job keeps the backend busy while four more fill the queue
        launch_job(AddrW'($urandom), AddrW'($urandom), LenW'(LongLen), id);
        write_reg(REG_LEN, DataW'(2));
        repeat (`DMA_QUEUE_DEPTH) read_reg(REG_NEXT_ID, data);
        read_reg(REG_NEXT_ID, data);
        read_reg(REG_STATUS, data);
        wait_queue_room();
        read_reg(REG_NEXT_ID, data);
        last_id = data[IdW-1:0];
        wait_for_done(last_id);

        // random traffic, long enough to wrap both counters
        for (int i = 0; i < NumXfers; i++) begin
            wait_queue_room();
            launch_job(AddrW'($urandom), AddrW'($urandom),
                       LenW'($urandom_range(MaxLen, 0)), last_id);
            if (i % 5 == 4) read_reg(REG_DONE_ID, data);
        end
        wait_for_done(last_id);
        read_reg(REG_STATUS, data);
        repeat (4) @(negedge clk);

        // stimulus must have reached each case
        if (full_hits == 0) report_issue("no launch was tried while the queue was full");
        if (next_wrap_hits == 0) report_issue("the next id never wrapped");
        if (done_wrap_hits == 0) report_issue("the done id never wrapped");
        if (zero_len_hits == 0) report_issue("no zero length transfer was run");
        if (m_busy || (model_q.size() != 0)) report_issue("transfers left over at the end");

        $display("summary: %0d errors, %0d reads, %0d beats", errors, n_reads, n_beats);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles with %0d errors", WatchdogCycles, errors);
        $display("tests failed");
        $finish;
    end

endmodule : tb_dma_frontend

`default_nettype wire
